// ==== Makefile ====
# Verilator build and run of the integer core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/mips_pkg.sv ====
// shared widths, opcode and funct codes, operation enums and stage payload structs
`default_nettype none

package mips_pkg;

   localparam int xlen = 32;

   typedef logic [4:0]      reg_idx_t;
   typedef logic [xlen-1:0] word_t;

   // primary opcodes, instruction bits 31:26
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_addiu = 6'h09;
   localparam logic [5:0] op_slti  = 6'h0a;
   localparam logic [5:0] op_sltiu = 6'h0b;
   localparam logic [5:0] op_andi  = 6'h0c;
   localparam logic [5:0] op_ori   = 6'h0d;
   localparam logic [5:0] op_xori  = 6'h0e;
   localparam logic [5:0] op_lui   = 6'h0f;
   localparam logic [5:0] op_lb    = 6'h20;
   localparam logic [5:0] op_lh    = 6'h21;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_lbu   = 6'h24;
   localparam logic [5:0] op_lhu   = 6'h25;
   localparam logic [5:0] op_sb    = 6'h28;
   localparam logic [5:0] op_sh    = 6'h29;
   localparam logic [5:0] op_sw    = 6'h2b;

   // r-type funct codes, instruction bits 5:0
   localparam logic [5:0] fn_sll  = 6'h00;
   localparam logic [5:0] fn_srl  = 6'h02;
   localparam logic [5:0] fn_sra  = 6'h03;
   localparam logic [5:0] fn_sllv = 6'h04;
   localparam logic [5:0] fn_srlv = 6'h06;
   localparam logic [5:0] fn_srav = 6'h07;
   localparam logic [5:0] fn_add  = 6'h20;
   localparam logic [5:0] fn_addu = 6'h21;
   localparam logic [5:0] fn_sub  = 6'h22;
   localparam logic [5:0] fn_subu = 6'h23;
   localparam logic [5:0] fn_and  = 6'h24;
   localparam logic [5:0] fn_or   = 6'h25;
   localparam logic [5:0] fn_xor  = 6'h26;
   localparam logic [5:0] fn_nor  = 6'h27;
   localparam logic [5:0] fn_slt  = 6'h2a;
   localparam logic [5:0] fn_sltu = 6'h2b;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt,
      alu_sltu, alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav
   } alu_op_e;

   // ten memory-side operations, so four bits are needed
   typedef enum logic [3:0] {
      mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw,
      mem_sb, mem_sh, mem_sw, mem_lui
   } mem_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    sign_ext;
      logic    wr_en;
      mem_op_e mem_op;
   } ctrl_t;

   // decode to execute
   typedef struct packed {
      ctrl_t      ctrl;
      word_t      rs_val;
      word_t      rt_val;
      word_t      imm;
      logic [4:0] shamt;
      reg_idx_t   wr_reg;
      word_t      upper_imm;
   } ex_pkt_t;

   // execute to memory
   typedef struct packed {
      mem_op_e    mem_op;
      logic       wr_en;
      reg_idx_t   wr_reg;
      word_t      alu_result;
      word_t      st_data;
      logic [3:0] byte_en;
   } mem_pkt_t;

   // register write as seen at the core boundary, 38 bits
   typedef struct packed {
      logic     valid;
      reg_idx_t wr_reg;
      word_t    data;
   } wb_t;

endpackage

`default_nettype wire

// ==== execute/alu.sv ====
// integer alu: add, sub, logic ops, set-less-than and shifts
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  mips_pkg::alu_op_e op,
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  logic [4:0]        shamt,
   output mips_pkg::word_t   result
);
   import mips_pkg::*;

   logic lt_signed;
   logic lt_unsigned;

   assign lt_signed   = ($signed(a) < $signed(b));
   assign lt_unsigned = (a < b);

   // a is rs, b is rt or the extended immediate
   always_comb begin
      case (op)
         // wraps, no overflow trap
         alu_add:  result = a + b;
         alu_sub:  result = a - b;
         alu_and:  result = a & b;
         alu_or:   result = a | b;
         alu_xor:  result = a ^ b;
         alu_nor:  result = ~(a | b);
         alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
         alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
         // shifts act on rt, amount from shamt
         alu_sll:  result = b << shamt;
         alu_srl:  result = b >> shamt;
         alu_sra:  result = word_t'($signed(b) >>> shamt);
         // variable shifts take the amount from rs
         alu_sllv: result = b << a[4:0];
         alu_srlv: result = b >> a[4:0];
         alu_srav: result = word_t'($signed(b) >>> a[4:0]);
         default:  result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
// execute stage: pipeline register, operand select, store lane alignment
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               ex_valid,
   input  mips_pkg::ex_pkt_t  ex_pkt,
   output logic               mem_valid,
   output mips_pkg::mem_pkt_t mem_pkt
);
   import mips_pkg::*;

   ex_pkt_t    pkt_q;
   logic       valid_q;
   word_t      op_b;
   word_t      alu_result;
   logic [1:0] offset;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      pkt_q <= ex_pkt;
   end

   // immediate or rt as second operand
   assign op_b = pkt_q.ctrl.use_imm ? pkt_q.imm : pkt_q.rt_val;

   alu u_alu (
      .op     (pkt_q.ctrl.alu_op),
      .a      (pkt_q.rs_val),
      .b      (op_b),
      .shamt  (pkt_q.shamt),
      .result (alu_result)
   );

   // byte lane within the word
   assign offset = alu_result[1:0];

   always_comb begin
      mem_pkt.mem_op     = pkt_q.ctrl.mem_op;
      mem_pkt.wr_en      = pkt_q.ctrl.wr_en;
      mem_pkt.wr_reg     = pkt_q.wr_reg;
      mem_pkt.alu_result = (pkt_q.ctrl.mem_op == mem_lui) ? pkt_q.upper_imm : alu_result;
      mem_pkt.st_data    = pkt_q.rt_val;
      mem_pkt.byte_en    = 4'b0000;
      case (pkt_q.ctrl.mem_op)
         mem_sb: begin
            mem_pkt.st_data = {24'h000000, pkt_q.rt_val[7:0]} << {offset, 3'b000};
            mem_pkt.byte_en = 4'b0001 << offset;
         end
         // halfword lane from bit 1, bit 0 ignored
         mem_sh: begin
            mem_pkt.st_data = {16'h0000, pkt_q.rt_val[15:0]} << {offset[1], 4'b0000};
            mem_pkt.byte_en = 4'b0011 << {offset[1], 1'b0};
         end
         mem_sw:  mem_pkt.byte_en = 4'b1111;
         default: mem_pkt.byte_en = 4'b0000;
      endcase
   end

   assign mem_valid = valid_q;

endmodule

`default_nettype wire

// ==== sim.f ====
common/mips_pkg.sv
execute/alu.sv
execute/execute_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/mem_stage.sv
src/mips_lite_core.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== src/decode_stage.sv ====
// decode stage: instruction register, field decode, immediate extension, operand read
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               inst_valid,
   input  mips_pkg::word_t    inst,
   output mips_pkg::reg_idx_t rs_idx,
   output mips_pkg::reg_idx_t rt_idx,
   input  mips_pkg::word_t    rs_val,
   input  mips_pkg::word_t    rt_val,
   output logic               ex_valid,
   output mips_pkg::ex_pkt_t  ex_pkt
);
   import mips_pkg::*;

   word_t       ir;
   logic        ir_valid;
   logic [5:0]  opcode;
   logic [5:0]  funct;
   logic [15:0] imm16;
   logic        is_rtype;
   ctrl_t       ctrl;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ir_valid <= 1'b0;
      end else begin
         ir_valid <= inst_valid;
      end
   end

   // a bubble leaves the old word in place, ir_valid marks it dead
   always_ff @(posedge clk) begin
      if (inst_valid) begin
         ir <= inst;
      end
   end

   assign opcode   = ir[31:26];
   assign funct    = ir[5:0];
   assign imm16    = ir[15:0];
   assign rs_idx   = ir[25:21];
   assign rt_idx   = ir[20:16];
   assign is_rtype = (opcode == op_rtype);

   // start from an immediate-class op, then narrow by opcode
   always_comb begin
      ctrl = '{alu_op: alu_add, use_imm: 1'b1, sign_ext: 1'b1, wr_en: 1'b1, mem_op: mem_none};
      case (opcode)
         op_rtype: begin
            ctrl.use_imm = 1'b0;
            case (funct)
               fn_add, fn_addu: ctrl.alu_op = alu_add;
               fn_sub, fn_subu: ctrl.alu_op = alu_sub;
               fn_and:          ctrl.alu_op = alu_and;
               fn_or:           ctrl.alu_op = alu_or;
               fn_xor:          ctrl.alu_op = alu_xor;
               fn_nor:          ctrl.alu_op = alu_nor;
               fn_slt:          ctrl.alu_op = alu_slt;
               fn_sltu:         ctrl.alu_op = alu_sltu;
               fn_sll:          ctrl.alu_op = alu_sll;
               fn_srl:          ctrl.alu_op = alu_srl;
               fn_sra:          ctrl.alu_op = alu_sra;
               fn_sllv:         ctrl.alu_op = alu_sllv;
               fn_srlv:         ctrl.alu_op = alu_srlv;
               fn_srav:         ctrl.alu_op = alu_srav;
               // unknown funct turns into a no-op
               default:         ctrl.wr_en = 1'b0;
            endcase
         end
         op_addi, op_addiu: ctrl.alu_op = alu_add;
         op_slti:           ctrl.alu_op = alu_slt;
         // sltiu still sign-extends, compare is unsigned
         op_sltiu:          ctrl.alu_op = alu_sltu;
         op_andi:           ctrl.alu_op = alu_and;
         op_ori:            ctrl.alu_op = alu_or;
         op_xori:           ctrl.alu_op = alu_xor;
         op_lui:            ctrl.mem_op = mem_lui;
         op_lb:             ctrl.mem_op = mem_lb;
         op_lbu:            ctrl.mem_op = mem_lbu;
         op_lh:             ctrl.mem_op = mem_lh;
         op_lhu:            ctrl.mem_op = mem_lhu;
         op_lw:             ctrl.mem_op = mem_lw;
         op_sb:             ctrl.mem_op = mem_sb;
         op_sh:             ctrl.mem_op = mem_sh;
         op_sw:             ctrl.mem_op = mem_sw;
         default:           ctrl.wr_en = 1'b0;
      endcase
      // logical immediates are zero-extended
      if (opcode inside {op_andi, op_ori, op_xori}) begin
         ctrl.sign_ext = 1'b0;
      end
      // stores write memory only
      if (ctrl.mem_op inside {mem_sb, mem_sh, mem_sw}) begin
         ctrl.wr_en = 1'b0;
      end
   end

   always_comb begin
      ex_pkt.ctrl      = ctrl;
      ex_pkt.rs_val    = rs_val;
      ex_pkt.rt_val    = rt_val;
      ex_pkt.imm       = ctrl.sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
      ex_pkt.shamt     = ir[10:6];
      // rd for r-type, rt for everything else
      ex_pkt.wr_reg    = is_rtype ? ir[15:11] : rt_idx;
      ex_pkt.upper_imm = {imm16, 16'h0000};
   end

   assign ex_valid = ir_valid;

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
// memory stage: pipeline register, data memory port, load alignment, writeback register
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               mem_valid,
   input  mips_pkg::mem_pkt_t mem_pkt,
   output logic [29:0]        mem_addr,
   output mips_pkg::word_t    mem_wdata,
   output logic [3:0]         mem_be,
   input  mips_pkg::word_t    mem_rdata,
   output mips_pkg::wb_t      wb
);
   import mips_pkg::*;

   mem_pkt_t pkt_q;
   logic     valid_q;
   word_t    shifted;
   word_t    load_data;
   logic     wb_valid_q;
   reg_idx_t wb_reg_q;
   word_t    wb_data_q;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= mem_valid;
      end
   end

   always_ff @(posedge clk) begin
      pkt_q <= mem_pkt;
   end

   // word address, lane already placed by execute
   assign mem_addr  = pkt_q.alu_result[xlen-1:2];
   assign mem_wdata = pkt_q.st_data;
   // a dead slot must not write memory
   assign mem_be    = valid_q ? pkt_q.byte_en : 4'b0000;

   // bring the addressed byte or halfword down to bit 0
   assign shifted = mem_rdata >> {pkt_q.alu_result[1:0], 3'b000};

   always_comb begin
      case (pkt_q.mem_op)
         mem_lb:  load_data = {{24{shifted[7]}}, shifted[7:0]};
         mem_lbu: load_data = {24'h000000, shifted[7:0]};
         mem_lh:  load_data = {{16{shifted[15]}}, shifted[15:0]};
         mem_lhu: load_data = {16'h0000, shifted[15:0]};
         mem_lw:  load_data = mem_rdata;
         // alu ops and lui carry their value in alu_result
         default: load_data = pkt_q.alu_result;
      endcase
   end

   // writes to register 0 never show up on wb
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_valid_q <= 1'b0;
      end else begin
         wb_valid_q <= valid_q && pkt_q.wr_en && (pkt_q.wr_reg != '0);
      end
   end

   always_ff @(posedge clk) begin
      wb_reg_q  <= pkt_q.wr_reg;
      wb_data_q <= load_data;
   end

   assign wb = '{valid: wb_valid_q, wr_reg: wb_reg_q, data: wb_data_q};

endmodule

`default_nettype wire

// ==== src/mips_lite_core.sv ====
// four-stage integer core top level, stage instances and their wiring
`timescale 1ns/1ps
`default_nettype none

module mips_lite_core (
   input  logic            clk,
   input  logic            rst_b,
   input  logic            inst_valid,
   input  mips_pkg::word_t inst,
   input  mips_pkg::word_t mem_rdata,
   output logic [29:0]     mem_addr,
   output mips_pkg::word_t mem_wdata,
   output logic [3:0]      mem_be,
   output mips_pkg::wb_t   wb
);
   import mips_pkg::*;

   // decode to register file
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_val;
   word_t    rt_val;

   // stage payloads
   logic     ex_valid;
   ex_pkt_t  ex_pkt;
   logic     mem_valid;
   mem_pkt_t mem_pkt;

   decode_stage u_decode (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_valid (inst_valid),
      .inst       (inst),
      .rs_idx     (rs_idx),
      .rt_idx     (rt_idx),
      .rs_val     (rs_val),
      .rt_val     (rt_val),
      .ex_valid   (ex_valid),
      .ex_pkt     (ex_pkt)
   );

   // written from the wb port, which also feeds the read bypass
   reg_file u_reg_file (
      .clk    (clk),
      .rst_b  (rst_b),
      .rs_idx (rs_idx),
      .rt_idx (rt_idx),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .wb     (wb)
   );

   execute_stage u_execute (
      .clk       (clk),
      .rst_b     (rst_b),
      .ex_valid  (ex_valid),
      .ex_pkt    (ex_pkt),
      .mem_valid (mem_valid),
      .mem_pkt   (mem_pkt)
   );

   mem_stage u_mem (
      .clk       (clk),
      .rst_b     (rst_b),
      .mem_valid (mem_valid),
      .mem_pkt   (mem_pkt),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_be    (mem_be),
      .mem_rdata (mem_rdata),
      .wb        (wb)
   );

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// 32x32 register file, zero register, two bypassed read ports
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   output mips_pkg::word_t    rs_val,
   output mips_pkg::word_t    rt_val,
   input  mips_pkg::wb_t      wb
);
   import mips_pkg::*;

   word_t regs [32];

   // wb.valid is never set for register 0, so it stays zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.wr_reg] <= wb.data;
      end
   end

   // reads see the write that lands at the end of this cycle
   assign rs_val = (rs_idx == '0)                       ? '0      :
                   (wb.valid && (wb.wr_reg == rs_idx)) ? wb.data :
                                                         regs[rs_idx];

   assign rt_val = (rt_idx == '0)                       ? '0      :
                   (wb.valid && (wb.wr_reg == rt_idx)) ? wb.data :
                                                         regs[rt_idx];

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
// checker matching writeback and memory-write events against the expectation of each row
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::wb_t      wb,
   input  logic [29:0]        mem_addr,
   input  logic [3:0]         mem_be,
   input  mips_pkg::word_t    mem_wdata,
   input  logic               exp_start,
   input  logic [1:0]         exp_kind,
   input  mips_pkg::reg_idx_t exp_reg,
   input  mips_pkg::word_t    exp_data,
   input  logic [3:0]         exp_be,
   input  logic [29:0]        exp_addr,
   input  int                 exp_row,
   output logic               row_done,
   output int                 pass_cnt,
   output int                 err_cnt
);
   import mips_pkg::*;

   localparam logic [1:0] k_none  = 2'd0;
   localparam logic [1:0] k_wb    = 2'd1;
   localparam logic [1:0] k_store = 2'd2;
   // event wait in cycles well past the pipeline depth
   localparam int window = 10;

   logic        busy;
   int          age;
   logic [1:0]  kind_q;
   reg_idx_t    reg_q;
   word_t       data_q;
   logic [3:0]  be_q;
   logic [29:0] addr_q;
   int          row_q;
   word_t       lane_mask;
   logic        hit;

   // unwritten lanes of the store word carry no meaning
   assign lane_mask = {{8{be_q[3]}}, {8{be_q[2]}}, {8{be_q[1]}}, {8{be_q[0]}}};

   // event the pending row is waiting for
   always_comb begin
      case (kind_q)
         k_wb:    hit = wb.valid;
         k_store: hit = (mem_be != 4'h0);
         default: hit = wb.valid || (mem_be != 4'h0);
      endcase
   end

   task automatic judge_event();
      int bad;
      bad = 0;
      if (kind_q == k_wb) begin
         if (wb.wr_reg !== reg_q) begin
            $display("mismatch row %0d wb.wr_reg: expected 0x%h, got 0x%h",
                     row_q, reg_q, wb.wr_reg);
            bad++;
         end
         if (wb.data !== data_q) begin
            $display("mismatch row %0d wb.data: expected 0x%h, got 0x%h",
                     row_q, data_q, wb.data);
            bad++;
         end
      end else if (kind_q == k_store) begin
         if (mem_addr !== addr_q) begin
            $display("mismatch row %0d mem_addr: expected 0x%h, got 0x%h",
                     row_q, addr_q, mem_addr);
            bad++;
         end
         if (mem_be !== be_q) begin
            $display("mismatch row %0d mem_be: expected 0x%h, got 0x%h",
                     row_q, be_q, mem_be);
            bad++;
         end
         if ((mem_wdata & lane_mask) !== (data_q & lane_mask)) begin
            $display("mismatch row %0d mem_wdata: expected 0x%h, got 0x%h",
                     row_q, data_q & lane_mask, mem_wdata & lane_mask);
            bad++;
         end
      end else begin
         $display("row %0d: a register write or store showed up for an instruction %s",
                  row_q, "that writes nothing");
         bad++;
      end
      if (bad == 0) begin
         $display("row %0d ok", row_q);
         pass_cnt <= pass_cnt + 1;
      end else begin
         $display("row %0d failed", row_q);
         err_cnt <= err_cnt + 1;
      end
   endtask

   // sampled on the falling edge where DUT outputs and tb inputs have settled
   always @(negedge clk) begin
      row_done <= 1'b0;
      if (!rst_b) begin
         busy     <= 1'b0;
         age      <= 0;
         kind_q   <= k_none;
         pass_cnt <= 0;
         err_cnt  <= 0;
      end else if (!busy) begin
         if (exp_start) begin
            busy   <= 1'b1;
            age    <= 0;
            kind_q <= exp_kind;
            reg_q  <= exp_reg;
            data_q <= exp_data;
            be_q   <= exp_be;
            addr_q <= exp_addr;
            row_q  <= exp_row;
         end else if (wb.valid || (mem_be != 4'h0)) begin
            // nothing is pending, so any write here is an extra one
            $display("a register write or store showed up with no instruction waiting for it");
            err_cnt <= err_cnt + 1;
         end
      end else if (hit) begin
         busy     <= 1'b0;
         row_done <= 1'b1;
         judge_event();
      end else if (age == window) begin
         busy     <= 1'b0;
         row_done <= 1'b1;
         // silence is the right answer only for a no-write row
         if (kind_q == k_none) begin
            $display("row %0d ok", row_q);
            pass_cnt <= pass_cnt + 1;
         end else begin
            $display("row %0d: expected register write or store never arrived in %0d cycles",
                     row_q, window);
            err_cnt <= err_cnt + 1;
         end
      end else begin
         age <= age + 1;
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
// testbench top with clock, reset, data memory model, instruction table and issue loop
`timescale 1ns/1ps
`default_nettype none

module tb_top;
   import mips_pkg::*;

   // what a row expects at the core boundary
   localparam logic [1:0] k_none  = 2'd0;
   localparam logic [1:0] k_wb    = 2'd1;
   localparam logic [1:0] k_store = 2'd2;
   localparam int row_timeout = 20;

   typedef struct packed {
      word_t       inst;
      logic [3:0]  gap;
      logic [1:0]  kind;
      reg_idx_t    rd;
      word_t       data;
      logic [3:0]  be;
      logic [29:0] addr;
   } row_t;

   logic        clk = 1'b0;
   logic        rst_b;
   logic        inst_valid;
   word_t       inst;
   word_t       mem_rdata;
   logic [29:0] mem_addr;
   word_t       mem_wdata;
   logic [3:0]  mem_be;
   wb_t         wb;

   // expectation handed to the checker
   logic        exp_start;
   logic [1:0]  exp_kind;
   reg_idx_t    exp_reg;
   word_t       exp_data;
   logic [3:0]  exp_be;
   logic [29:0] exp_addr;
   int          exp_row;
   logic        row_done;
   int          pass_cnt;
   int          err_cnt;
   int          lost_cnt;

   word_t mem [16];
   row_t  rows [$];

   always #5 clk = ~clk;

   mips_lite_core dut (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_valid (inst_valid),
      .inst       (inst),
      .mem_rdata  (mem_rdata),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_be     (mem_be),
      .wb         (wb)
   );

   tb_checker chk (
      .clk       (clk),
      .rst_b     (rst_b),
      .wb        (wb),
      .mem_addr  (mem_addr),
      .mem_be    (mem_be),
      .mem_wdata (mem_wdata),
      .exp_start (exp_start),
      .exp_kind  (exp_kind),
      .exp_reg   (exp_reg),
      .exp_data  (exp_data),
      .exp_be    (exp_be),
      .exp_addr  (exp_addr),
      .exp_row   (exp_row),
      .row_done  (row_done),
      .pass_cnt  (pass_cnt),
      .err_cnt   (err_cnt)
   );

   // 16-word data memory with combinational read and byte-enabled write
   assign mem_rdata = mem[mem_addr[3:0]];

   always @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         // preload depends on the whole word index
         for (int i = 0; i < 16; i++) begin
            mem[i] <= (word_t'(i) * 32'h0101_0101) ^ 32'hf00f_0000;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (mem_be[b]) begin
               mem[mem_addr[3:0]][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
         end
      end
   end

   function automatic word_t enc_r(input logic [5:0] fn, input reg_idx_t rs, input reg_idx_t rt,
                                   input reg_idx_t rd, input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
                                   input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic add_row(input word_t w, input logic [3:0] gap, input logic [1:0] kind,
                          input reg_idx_t rd, input word_t data, input logic [3:0] be);
      row_t r;
      r = '{inst: w, gap: gap, kind: kind, rd: rd, data: data, be: be, addr: '0};
      rows.push_back(r);
   endtask

   task automatic queue_store(input word_t w, input logic [3:0] gap, input word_t data,
                              input logic [3:0] be, input logic [29:0] addr);
      row_t r;
      r = '{inst: w, gap: gap, kind: k_store, rd: 5'd0, data: data, be: be, addr: addr};
      rows.push_back(r);
   endtask

   task automatic fill_table();
      // immediates with logical ones zero-extended
      add_row(enc_i(op_ori, 5'd0, 5'd1, 16'h1234), 4'd3, k_wb, 5'd1, 32'h0000_1234, 4'h0);
      add_row(enc_i(op_lui, 5'd0, 5'd2, 16'h8765), 4'd3, k_wb, 5'd2, 32'h8765_0000, 4'h0);
      add_row(enc_i(op_addiu, 5'd0, 5'd3, 16'hfffc), 4'd3, k_wb, 5'd3, 32'hffff_fffc, 4'h0);
      add_row(enc_i(op_andi, 5'd3, 5'd4, 16'hff0f), 4'd3, k_wb, 5'd4, 32'h0000_ff0c, 4'h0);
      add_row(enc_i(op_xori, 5'd1, 5'd5, 16'hffff), 4'd3, k_wb, 5'd5, 32'h0000_edcb, 4'h0);
      add_row(enc_i(op_ori, 5'd2, 5'd2, 16'h4321), 4'd5, k_wb, 5'd2, 32'h8765_4321, 4'h0);
      // sltiu sign-extends 0xffff and then compares unsigned
      add_row(enc_i(op_sltiu, 5'd1, 5'd30, 16'hffff), 4'd3, k_wb, 5'd30, 32'h1, 4'h0);
      // r-type on r1=1234, r2=87654321, r3=-4, r5=edcb
      add_row(enc_r(fn_add, 5'd1, 5'd3, 5'd6, 5'd0), 4'd3, k_wb, 5'd6, 32'h0000_1230, 4'h0);
      add_row(enc_r(fn_sub, 5'd1, 5'd5, 5'd7, 5'd0), 4'd3, k_wb, 5'd7, 32'hffff_2469, 4'h0);
      add_row(enc_r(fn_and, 5'd2, 5'd5, 5'd8, 5'd0), 4'd3, k_wb, 5'd8, 32'h0000_4101, 4'h0);
      add_row(enc_r(fn_or, 5'd1, 5'd2, 5'd9, 5'd0), 4'd3, k_wb, 5'd9, 32'h8765_5335, 4'h0);
      add_row(enc_r(fn_xor, 5'd2, 5'd3, 5'd10, 5'd0), 4'd3, k_wb, 5'd10, 32'h789a_bcdd, 4'h0);
      add_row(enc_r(fn_nor, 5'd1, 5'd5, 5'd11, 5'd0), 4'd3, k_wb, 5'd11, 32'hffff_0000, 4'h0);
      // -4 is below 0x1234 signed but above it unsigned
      add_row(enc_r(fn_slt, 5'd3, 5'd1, 5'd12, 5'd0), 4'd3, k_wb, 5'd12, 32'h1, 4'h0);
      add_row(enc_r(fn_sltu, 5'd3, 5'd1, 5'd13, 5'd0), 4'd3, k_wb, 5'd13, 32'h0, 4'h0);
      add_row(enc_r(fn_slt, 5'd2, 5'd3, 5'd14, 5'd0), 4'd3, k_wb, 5'd14, 32'h1, 4'h0);
      // shifts with variable amounts from r6 (16) and r3 (28)
      add_row(enc_r(fn_sll, 5'd0, 5'd1, 5'd15, 5'd4), 4'd3, k_wb, 5'd15, 32'h0001_2340, 4'h0);
      add_row(enc_r(fn_srl, 5'd0, 5'd2, 5'd16, 5'd8), 4'd3, k_wb, 5'd16, 32'h0087_6543, 4'h0);
      add_row(enc_r(fn_sra, 5'd0, 5'd2, 5'd17, 5'd8), 4'd3, k_wb, 5'd17, 32'hff87_6543, 4'h0);
      add_row(enc_r(fn_sllv, 5'd6, 5'd1, 5'd18, 5'd0), 4'd3, k_wb, 5'd18, 32'h1234_0000, 4'h0);
      add_row(enc_r(fn_srlv, 5'd3, 5'd2, 5'd19, 5'd0), 4'd3, k_wb, 5'd19, 32'h0000_0008, 4'h0);
      add_row(enc_r(fn_srav, 5'd3, 5'd2, 5'd20, 5'd0), 4'd3, k_wb, 5'd20, 32'hffff_fff8, 4'h0);
      // stores fill words 4, 5 and 6
      queue_store(enc_i(op_sb, 5'd0, 5'd2, 16'h0010), 4'd3, 32'h0000_0021, 4'h1, 30'h4);
      queue_store(enc_i(op_sb, 5'd0, 5'd2, 16'h0011), 4'd3, 32'h0000_2100, 4'h2, 30'h4);
      queue_store(enc_i(op_sb, 5'd0, 5'd1, 16'h0012), 4'd3, 32'h0034_0000, 4'h4, 30'h4);
      queue_store(enc_i(op_sb, 5'd0, 5'd5, 16'h0013), 4'd3, 32'hcb00_0000, 4'h8, 30'h4);
      queue_store(enc_i(op_sh, 5'd0, 5'd2, 16'h0014), 4'd3, 32'h0000_4321, 4'h3, 30'h5);
      queue_store(enc_i(op_sh, 5'd0, 5'd3, 16'h0016), 4'd3, 32'hfffc_0000, 4'hc, 30'h5);
      queue_store(enc_i(op_sw, 5'd0, 5'd2, 16'h0018), 4'd3, 32'h8765_4321, 4'hf, 30'h6);
      // loads read back word 4 (cb342121) and word 5 (fffc4321)
      add_row(enc_i(op_lb, 5'd0, 5'd21, 16'h0013), 4'd3, k_wb, 5'd21, 32'hffff_ffcb, 4'h0);
      add_row(enc_i(op_lbu, 5'd0, 5'd22, 16'h0013), 4'd3, k_wb, 5'd22, 32'h0000_00cb, 4'h0);
      add_row(enc_i(op_lh, 5'd0, 5'd23, 16'h0016), 4'd3, k_wb, 5'd23, 32'hffff_fffc, 4'h0);
      add_row(enc_i(op_lhu, 5'd0, 5'd24, 16'h0016), 4'd3, k_wb, 5'd24, 32'h0000_fffc, 4'h0);
      add_row(enc_i(op_lw, 5'd0, 5'd25, 16'h0018), 4'd3, k_wb, 5'd25, 32'h8765_4321, 4'h0);
      add_row(enc_i(op_lh, 5'd0, 5'd26, 16'h0010), 4'd3, k_wb, 5'd26, 32'h0000_2121, 4'h0);
      // word 9 still holds its preload f9060909
      add_row(enc_i(op_lw, 5'd0, 5'd27, 16'h0024), 4'd3, k_wb, 5'd27, 32'hf906_0909, 4'h0);
      add_row(enc_i(op_lb, 5'd0, 5'd28, 16'h0027), 4'd3, k_wb, 5'd28, 32'hffff_fff9, 4'h0);
      // r0 write is dropped and r0 still reads zero
      add_row(enc_i(op_addiu, 5'd0, 5'd0, 16'h0005), 4'd3, k_none, 5'd0, 32'h0, 4'h0);
      add_row(enc_i(op_addiu, 5'd0, 5'd29, 16'h0077), 4'd3, k_wb, 5'd29, 32'h0000_0077, 4'h0);
      // unknown opcode and unknown funct do nothing
      add_row(32'hfc00_0000, 4'd3, k_none, 5'd0, 32'h0, 4'h0);
      add_row(enc_r(6'h3f, 5'd1, 5'd2, 5'd31, 5'd0), 4'd3, k_none, 5'd0, 32'h0, 4'h0);
   endtask

   initial begin
      int   t;
      logic got;
      fill_table();
      rst_b      = 1'b0;
      inst_valid = 1'b0;
      inst       = '0;
      exp_start  = 1'b0;
      exp_kind   = k_none;
      exp_reg    = '0;
      exp_data   = '0;
      exp_be     = '0;
      exp_addr   = '0;
      exp_row    = 0;
      lost_cnt   = 0;
      repeat (10) @(posedge clk);
      #1 rst_b = 1'b1;
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         #1;
         // one-cycle issue with the expectation alongside
         inst_valid = 1'b1;
         inst       = rows[i].inst;
         exp_start  = 1'b1;
         exp_kind   = rows[i].kind;
         exp_reg    = rows[i].rd;
         exp_data   = rows[i].data;
         exp_be     = rows[i].be;
         exp_addr   = rows[i].addr;
         exp_row    = i;
         @(posedge clk);
         #1;
         inst_valid = 1'b0;
         exp_start  = 1'b0;
         got = 1'b0;
         for (t = 0; t < row_timeout && !got; t++) begin
            @(posedge clk);
            got = row_done;
         end
         if (!got) begin
            $display("row %0d: checker did not finish the row within %0d cycles", i, row_timeout);
            lost_cnt++;
         end
         repeat (rows[i].gap) @(posedge clk);
      end
      repeat (3) @(posedge clk);
      $display("rows %0d, passed %0d, failed %0d, lost %0d",
               rows.size(), pass_cnt, err_cnt, lost_cnt);
      if (err_cnt == 0 && lost_cnt == 0 && pass_cnt == rows.size()) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
